/* hw/dcache_pkg.sv */
// cache geometry, vector types, operation encoding and address helpers
`default_nettype none

package dcache_pkg;

  // two ways, 256 sets of one word each
  localparam int WAY_CNT = 2;
  localparam int IDX_LEN = 8;
  localparam int TAG_LEN = 22;
  localparam int SET_CNT = 1 << IDX_LEN;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] strobe_t;
  typedef logic [IDX_LEN-1:0] idx_t;
  typedef logic [TAG_LEN-1:0] tag_t;

  // valid bit on top of the tag
  typedef logic [TAG_LEN:0] tag_entry_t;

  // one-hot way mask
  typedef logic [WAY_CNT-1:0] way_t;

  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_INV   = 2'd2
  } op_e;

  // set index from word address bits
  function automatic idx_t get_idx(input addr_t addr);
    return addr[IDX_LEN+1:2];
  endfunction

  function automatic tag_t get_tag(input addr_t addr);
    return addr[31:32-TAG_LEN];
  endfunction

endpackage

`default_nettype wire

/* hw/dcache_ram.sv */
// simple dual-port RAM with byte-lane write enables and a registered read
`timescale 1ns/1ps
`default_nettype none

module dcache_ram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 256
) (
  input  wire                     clk,
  input  wire [WIDTH/8-1:0]       wr_en_i,
  input  wire [$clog2(DEPTH)-1:0] wr_addr_i,
  input  wire [WIDTH-1:0]         wr_data_i,
  input  wire [$clog2(DEPTH)-1:0] rd_addr_i,
  output logic [WIDTH-1:0]        rd_data_o
);

  localparam int LANES = WIDTH / 8;

  logic [WIDTH-1:0] mem_q [DEPTH];

  always_ff @(posedge clk) begin
    for (int b = 0; b < WIDTH; b++) begin
      // bits past the last full lane follow that lane's enable
      if (wr_en_i[(b / 8 < LANES) ? b / 8 : LANES - 1]) begin
        mem_q[wr_addr_i][b] <= wr_data_i[b];
      end
    end
    // old data on a same-address collision
    rd_data_o <= mem_q[rd_addr_i];
  end

endmodule

`default_nettype wire

/* hw/dcache_rport.sv */
// read port: per-way data and tag RAMs, m1 write forwarding, hit compare, m2 FSM
`timescale 1ns/1ps
`default_nettype none

module dcache_rport (
  input  wire                                                clk,
  input  wire                                                rst_n,
  input  wire                                                ex_valid_i,
  input  wire dcache_pkg::op_e                               ex_op_i,
  input  wire dcache_pkg::addr_t                             ex_addr_i,
  input  wire dcache_pkg::word_t                             ex_wdata_i,
  input  wire dcache_pkg::strobe_t                           ex_strobe_i,
  input  wire                                                ex_uncached_i,
  output logic                                               busy_o,
  output dcache_pkg::word_t                                  rdata_o,
  output logic                                               rvalid_o,
  output logic                                               rf_req_o,
  output logic                                               unc_rd_o,
  output logic                                               unc_wr_o,
  output logic                                               inv_req_o,
  output dcache_pkg::way_t                                   hit_wr_o,
  output dcache_pkg::addr_t                                  wp_addr_o,
  output dcache_pkg::word_t                                  wp_wdata_o,
  output dcache_pkg::strobe_t                                wp_strobe_o,
  input  wire                                                wp_done_i,
  input  wire dcache_pkg::word_t                             wp_rdata_i,
  input  wire dcache_pkg::strobe_t [dcache_pkg::WAY_CNT-1:0] data_we_i,
  input  wire dcache_pkg::idx_t                              data_waddr_i,
  input  wire dcache_pkg::word_t                             data_wdata_i,
  input  wire dcache_pkg::way_t                              tag_we_i,
  input  wire dcache_pkg::idx_t                              tag_waddr_i,
  input  wire dcache_pkg::tag_entry_t                        tag_wdata_i,
  input  wire                                                init_busy_i
);

  typedef enum logic [2:0] {NORMAL, REFILL, UNC_READ, WRITE_MEM, INVOP, DONE} state_e;

  state_e state_q, state_d;
  logic m2_busy;
  logic stall_q;

  // m1 and m2 stage contents
  logic m1_valid_q, m1_unc_q, m2_valid_q, m2_unc_q;
  dcache_pkg::op_e m1_op_q, m2_op_q;
  dcache_pkg::addr_t m1_addr_q, m2_addr_q;
  dcache_pkg::word_t m1_wdata_q, m2_wdata_q;
  dcache_pkg::strobe_t m1_strobe_q, m2_strobe_q;
  dcache_pkg::idx_t m1_idx;
  dcache_pkg::way_t m1_hit, m2_hit_q;
  dcache_pkg::word_t [dcache_pkg::WAY_CNT-1:0] raw_data, m1_data, m1_data_q, m2_data_q;
  dcache_pkg::tag_entry_t [dcache_pkg::WAY_CNT-1:0] raw_tag, m1_tag, m1_tag_q;

  // write-port writes from the previous cycle
  dcache_pkg::strobe_t [dcache_pkg::WAY_CNT-1:0] prev_data_we;
  dcache_pkg::idx_t prev_data_waddr, prev_tag_waddr;
  dcache_pkg::word_t prev_data_wdata;
  dcache_pkg::way_t prev_tag_we;
  dcache_pkg::tag_entry_t prev_tag_wdata;

  dcache_pkg::word_t cap_q, result;

  assign m1_idx = dcache_pkg::get_idx(m1_addr_q);

  for (genvar w = 0; w < dcache_pkg::WAY_CNT; w++) begin : g_way
    dcache_ram #(
      .WIDTH($bits(dcache_pkg::word_t)),
      .DEPTH(dcache_pkg::SET_CNT)
    ) data_ram (
      .clk      (clk),
      .wr_en_i  (data_we_i[w]),
      .wr_addr_i(data_waddr_i),
      .wr_data_i(data_wdata_i),
      .rd_addr_i(dcache_pkg::get_idx(ex_addr_i)),
      .rd_data_o(raw_data[w])
    );

    dcache_ram #(
      .WIDTH($bits(dcache_pkg::tag_entry_t)),
      .DEPTH(dcache_pkg::SET_CNT)
    ) tag_ram (
      .clk      (clk),
      .wr_en_i  ({($bits(dcache_pkg::tag_entry_t) / 8){tag_we_i[w]}}),
      .wr_addr_i(tag_waddr_i),
      .wr_data_i(tag_wdata_i),
      .rd_addr_i(dcache_pkg::get_idx(ex_addr_i)),
      .rd_data_o(raw_tag[w])
    );

    // held RAM output while stalled, then older write, then current write on top
    always_comb begin
      m1_data[w] = stall_q ? m1_data_q[w] : raw_data[w];
      m1_tag[w] = stall_q ? m1_tag_q[w] : raw_tag[w];
      for (int b = 0; b < 4; b++) begin
        if (prev_data_we[w][b] && prev_data_waddr == m1_idx) begin
          m1_data[w][8*b +: 8] = prev_data_wdata[8*b +: 8];
        end
        if (data_we_i[w][b] && data_waddr_i == m1_idx) begin
          m1_data[w][8*b +: 8] = data_wdata_i[8*b +: 8];
        end
      end
      if (prev_tag_we[w] && prev_tag_waddr == m1_idx) begin
        m1_tag[w] = prev_tag_wdata;
      end
      if (tag_we_i[w] && tag_waddr_i == m1_idx) begin
        m1_tag[w] = tag_wdata_i;
      end
    end

    // uncached requests never hit
    assign m1_hit[w] = m1_tag[w][dcache_pkg::TAG_LEN] && !m1_unc_q &&
                       m1_tag[w][dcache_pkg::TAG_LEN-1:0] == dcache_pkg::get_tag(m1_addr_q);
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m1_valid_q <= 1'b0;
      m2_valid_q <= 1'b0;
      stall_q <= 1'b0;
      prev_data_we <= '0;
      prev_tag_we <= '0;
      state_q <= NORMAL;
      rvalid_o <= 1'b0;
    end else begin
      stall_q <= busy_o;
      prev_data_we <= data_we_i;
      prev_tag_we <= tag_we_i;
      state_q <= state_d;
      rvalid_o <= m2_valid_q && !m2_busy && m2_op_q == dcache_pkg::OP_READ;
      if (!busy_o) begin
        m1_valid_q <= ex_valid_i;
        m2_valid_q <= m1_valid_q;
      end
    end
  end

  always_ff @(posedge clk) begin
    prev_data_waddr <= data_waddr_i;
    prev_data_wdata <= data_wdata_i;
    prev_tag_waddr <= tag_waddr_i;
    prev_tag_wdata <= tag_wdata_i;
    m1_data_q <= m1_data;
    m1_tag_q <= m1_tag;
    if (!busy_o) begin
      m1_op_q <= ex_op_i;
      m1_addr_q <= ex_addr_i;
      m1_wdata_q <= ex_wdata_i;
      m1_strobe_q <= ex_strobe_i;
      m1_unc_q <= ex_uncached_i;
      m2_op_q <= m1_op_q;
      m2_addr_q <= m1_addr_q;
      m2_wdata_q <= m1_wdata_q;
      m2_strobe_q <= m1_strobe_q;
      m2_unc_q <= m1_unc_q;
      m2_hit_q <= m1_hit;
      m2_data_q <= m1_data;
    end
    if (wp_done_i) begin
      cap_q <= wp_rdata_i;
    end
    if (m2_valid_q && !m2_busy) begin
      rdata_o <= result;
    end
  end

  // m2 FSM that sends every write through memory
  always_comb begin
    state_d = state_q;
    m2_busy = 1'b0;
    case (state_q)
      NORMAL: begin
        if (m2_valid_q) begin
          m2_busy = 1'b1;
          if (m2_op_q == dcache_pkg::OP_INV) begin
            state_d = INVOP;
          end else if (m2_op_q == dcache_pkg::OP_WRITE) begin
            state_d = WRITE_MEM;
          end else if (m2_unc_q) begin
            state_d = UNC_READ;
          end else if (m2_hit_q == '0) begin
            state_d = REFILL;
          end else begin
            m2_busy = 1'b0;
          end
        end
      end
      DONE: state_d = NORMAL;
      default: begin
        m2_busy = 1'b1;
        if (wp_done_i) begin
          state_d = DONE;
        end
      end
    endcase
  end

  always_comb begin
    result = (state_q == DONE) ? cap_q : '0;
    for (int w = 0; w < dcache_pkg::WAY_CNT; w++) begin
      if (state_q != DONE && m2_hit_q[w]) begin
        result = result | m2_data_q[w];
      end
    end
  end

  assign busy_o = m2_busy || init_busy_i;
  assign rf_req_o = state_q == REFILL;
  assign unc_rd_o = state_q == UNC_READ;
  assign unc_wr_o = state_q == WRITE_MEM;
  assign inv_req_o = state_q == INVOP;
  assign hit_wr_o = unc_wr_o ? m2_hit_q : '0;
  assign wp_addr_o = m2_addr_q;
  assign wp_wdata_o = m2_wdata_q;
  assign wp_strobe_o = m2_strobe_q;

endmodule

`default_nettype wire

/* hw/dcache_wport.sv */
// write port: tag sweep, hit writes, refill, invalidate and memory sequencer
`timescale 1ns/1ps
`default_nettype none

module dcache_wport (
  input  wire                                         clk,
  input  wire                                         rst_n,
  input  wire                                         rf_req_i,
  input  wire                                         unc_rd_i,
  input  wire                                         unc_wr_i,
  input  wire                                         inv_req_i,
  input  wire dcache_pkg::way_t                       hit_wr_i,
  input  wire dcache_pkg::addr_t                      wp_addr_i,
  input  wire dcache_pkg::word_t                      wp_wdata_i,
  input  wire dcache_pkg::strobe_t                    wp_strobe_i,
  output logic                                        wp_done_o,
  output dcache_pkg::word_t                           wp_rdata_o,
  output dcache_pkg::strobe_t [dcache_pkg::WAY_CNT-1:0] data_we_o,
  output dcache_pkg::idx_t                            data_waddr_o,
  output dcache_pkg::word_t                           data_wdata_o,
  output dcache_pkg::way_t                            tag_we_o,
  output dcache_pkg::idx_t                            tag_waddr_o,
  output dcache_pkg::tag_entry_t                      tag_wdata_o,
  output logic                                        init_busy_o,
  output logic                                        mem_req_o,
  output logic                                        mem_we_o,
  output dcache_pkg::addr_t                           mem_addr_o,
  output dcache_pkg::word_t                           mem_wdata_o,
  output dcache_pkg::strobe_t                         mem_strb_o,
  input  wire                                         mem_ack_i,
  input  wire dcache_pkg::word_t                      mem_rdata_i
);

  typedef enum logic [2:0] {SWEEP, IDLE, MEM_RD, MEM_WR, FILL, INV, DONE} state_e;

  state_e state_q, state_d;
  dcache_pkg::idx_t sweep_q;
  dcache_pkg::idx_t idx;
  dcache_pkg::way_t victim;
  dcache_pkg::word_t rdata_q;

  // one round-robin bit per set picks the refill way
  logic [dcache_pkg::SET_CNT-1:0] rr_q;

  assign idx = dcache_pkg::get_idx(wp_addr_i);
  assign victim = dcache_pkg::way_t'(1) << rr_q[idx];

  always_comb begin
    state_d = state_q;
    case (state_q)
      SWEEP: begin
        if (sweep_q == '1) begin
          state_d = IDLE;
        end
      end
      IDLE: begin
        if (rf_req_i || unc_rd_i) begin
          state_d = MEM_RD;
        end else if (unc_wr_i) begin
          state_d = MEM_WR;
        end else if (inv_req_i) begin
          state_d = INV;
        end
      end
      MEM_RD: begin
        if (mem_ack_i) begin
          state_d = rf_req_i ? FILL : DONE;
        end
      end
      MEM_WR: begin
        if (mem_ack_i) begin
          state_d = DONE;
        end
      end
      FILL, INV: state_d = DONE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= SWEEP;
      sweep_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SWEEP) begin
        sweep_q <= sweep_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == SWEEP) begin
      rr_q[sweep_q] <= 1'b0;
    end else if (state_q == FILL) begin
      rr_q[idx] <= ~rr_q[idx];
    end
    if (state_q == MEM_RD && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  // single RAM write port, shared by all sequences
  always_comb begin
    data_we_o = '0;
    data_waddr_o = idx;
    data_wdata_o = (state_q == FILL) ? rdata_q : wp_wdata_i;
    tag_we_o = '0;
    tag_waddr_o = (state_q == SWEEP) ? sweep_q : idx;
    tag_wdata_o = '0;
    case (state_q)
      SWEEP, INV: tag_we_o = '1;
      IDLE: begin
        // hit update lands with the first request cycle
        if (unc_wr_i) begin
          for (int w = 0; w < dcache_pkg::WAY_CNT; w++) begin
            if (hit_wr_i[w]) begin
              data_we_o[w] = wp_strobe_i;
            end
          end
        end
      end
      FILL: begin
        for (int w = 0; w < dcache_pkg::WAY_CNT; w++) begin
          if (victim[w]) begin
            data_we_o[w] = '1;
          end
        end
        tag_we_o = victim;
        tag_wdata_o = {1'b1, dcache_pkg::get_tag(wp_addr_i)};
      end
      default: ;
    endcase
  end

  assign mem_req_o = state_q == MEM_RD || state_q == MEM_WR;
  assign mem_we_o = state_q == MEM_WR;
  assign mem_addr_o = wp_addr_i;
  assign mem_wdata_o = wp_wdata_i;
  // reads always fetch the whole word
  assign mem_strb_o = mem_we_o ? wp_strobe_i : '1;
  assign wp_done_o = state_q == DONE;
  assign wp_rdata_o = rdata_q;
  assign init_busy_o = state_q == SWEEP;

endmodule

`default_nettype wire

/* hw/dcache_top.sv */
// data cache top: read port and write port between pipeline and memory
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          ex_valid_i,
  input  wire dcache_pkg::op_e         ex_op_i,
  input  wire dcache_pkg::addr_t       ex_addr_i,
  input  wire dcache_pkg::word_t       ex_wdata_i,
  input  wire dcache_pkg::strobe_t     ex_strobe_i,
  input  wire                          ex_uncached_i,
  output logic                         busy_o,
  output dcache_pkg::word_t            rdata_o,
  output logic                         rvalid_o,
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output dcache_pkg::addr_t            mem_addr_o,
  output dcache_pkg::word_t            mem_wdata_o,
  output dcache_pkg::strobe_t          mem_strb_o,
  input  wire                          mem_ack_i,
  input  wire dcache_pkg::word_t       mem_rdata_i
);

  // read port requests
  logic rf_req, unc_rd, unc_wr, inv_req;
  dcache_pkg::way_t hit_wr;
  dcache_pkg::addr_t wp_addr;
  dcache_pkg::word_t wp_wdata;
  dcache_pkg::strobe_t wp_strobe;

  // write port results and RAM write buses
  logic wp_done, init_busy;
  dcache_pkg::word_t wp_rdata, data_wdata;
  dcache_pkg::strobe_t [dcache_pkg::WAY_CNT-1:0] data_we;
  dcache_pkg::idx_t data_waddr, tag_waddr;
  dcache_pkg::way_t tag_we;
  dcache_pkg::tag_entry_t tag_wdata;

  dcache_rport rport_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid_i),
    .ex_op_i      (ex_op_i),
    .ex_addr_i    (ex_addr_i),
    .ex_wdata_i   (ex_wdata_i),
    .ex_strobe_i  (ex_strobe_i),
    .ex_uncached_i(ex_uncached_i),
    .busy_o       (busy_o),
    .rdata_o      (rdata_o),
    .rvalid_o     (rvalid_o),
    .rf_req_o     (rf_req),
    .unc_rd_o     (unc_rd),
    .unc_wr_o     (unc_wr),
    .inv_req_o    (inv_req),
    .hit_wr_o     (hit_wr),
    .wp_addr_o    (wp_addr),
    .wp_wdata_o   (wp_wdata),
    .wp_strobe_o  (wp_strobe),
    .wp_done_i    (wp_done),
    .wp_rdata_i   (wp_rdata),
    .data_we_i    (data_we),
    .data_waddr_i (data_waddr),
    .data_wdata_i (data_wdata),
    .tag_we_i     (tag_we),
    .tag_waddr_i  (tag_waddr),
    .tag_wdata_i  (tag_wdata),
    .init_busy_i  (init_busy)
  );

  dcache_wport wport_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .rf_req_i    (rf_req),
    .unc_rd_i    (unc_rd),
    .unc_wr_i    (unc_wr),
    .inv_req_i   (inv_req),
    .hit_wr_i    (hit_wr),
    .wp_addr_i   (wp_addr),
    .wp_wdata_i  (wp_wdata),
    .wp_strobe_i (wp_strobe),
    .wp_done_o   (wp_done),
    .wp_rdata_o  (wp_rdata),
    .data_we_o   (data_we),
    .data_waddr_o(data_waddr),
    .data_wdata_o(data_wdata),
    .tag_we_o    (tag_we),
    .tag_waddr_o (tag_waddr),
    .tag_wdata_o (tag_wdata),
    .init_busy_o (init_busy),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_strb_o  (mem_strb_o),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i)
  );

endmodule

`default_nettype wire

/* verif/dcache_mem_model.sv */
// memory model with fixed-delay acknowledge, address-rule contents and a backdoor poke
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      req_i,
  input  wire                      we_i,
  input  wire dcache_pkg::addr_t   addr_i,
  input  wire dcache_pkg::word_t   wdata_i,
  input  wire dcache_pkg::strobe_t strb_i,
  output logic                     ack_o,
  output dcache_pkg::word_t        rdata_o
);

  localparam int DELAY = 3;
  localparam int SLOTS = 16;

  // words that no longer follow the address rule
  dcache_pkg::addr_t ov_addr [SLOTS];
  dcache_pkg::word_t ov_data [SLOTS];
  int ov_cnt = 0;
  int overflow_cnt = 0;
  int wait_cnt;

  function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t addr);
    dcache_pkg::addr_t aligned;
    dcache_pkg::word_t val;
    aligned = {addr[31:2], 2'b00};
    val = aligned ^ 32'hA5A5A5A5;
    for (int i = 0; i < ov_cnt; i++) begin
      if (ov_addr[i] == aligned) begin
        val = ov_data[i];
      end
    end
    return val;
  endfunction

  function automatic dcache_pkg::word_t write_merge(input dcache_pkg::word_t old_word,
                                                    input dcache_pkg::word_t new_word,
                                                    input dcache_pkg::strobe_t strb);
    dcache_pkg::word_t val;
    val = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        val[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return val;
  endfunction

  task automatic poke(input dcache_pkg::addr_t addr, input dcache_pkg::word_t data);
    dcache_pkg::addr_t aligned;
    int slot;
    aligned = {addr[31:2], 2'b00};
    slot = ov_cnt;
    for (int i = 0; i < ov_cnt; i++) begin
      if (ov_addr[i] == aligned) begin
        slot = i;
      end
    end
    if (slot >= SLOTS) begin
      overflow_cnt++;
      $display("ERROR: memory model is out of slots for address %h", addr);
    end else begin
      ov_addr[slot] = aligned;
      ov_data[slot] = data;
      if (slot == ov_cnt) begin
        ov_cnt++;
      end
    end
  endtask

  // ack rises DELAY cycles after the request, then drops for one cycle
  always @(posedge clk) begin
    if (!rst_n) begin
      ack_o <= 1'b0;
      wait_cnt <= 0;
    end else if (req_i && !ack_o) begin
      if (wait_cnt == DELAY - 1) begin
        ack_o <= 1'b1;
        rdata_o <= read_word(addr_i);
        wait_cnt <= 0;
        if (we_i) begin
          poke(addr_i, write_merge(read_word(addr_i), wdata_i, strb_i));
        end
      end else begin
        wait_cnt <= wait_cnt + 1;
      end
    end else begin
      ack_o <= 1'b0;
      wait_cnt <= 0;
    end
  end

endmodule

`default_nettype wire

/* verif/dcache_tb.sv */
// data cache testbench: clock, reset, stimulus table, expected results and checks
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int MAX_ENTRIES = 32;
  localparam int WAIT_LIMIT = 2000;

  logic clk;
  logic rst_n;
  logic ex_valid;
  dcache_pkg::op_e ex_op;
  dcache_pkg::addr_t ex_addr;
  dcache_pkg::word_t ex_wdata;
  dcache_pkg::strobe_t ex_strobe;
  logic ex_uncached;
  logic busy;
  dcache_pkg::word_t rdata;
  logic rvalid;

  logic mem_req, mem_we, mem_ack;
  dcache_pkg::addr_t mem_addr;
  dcache_pkg::word_t mem_wdata, mem_rdata;
  dcache_pkg::strobe_t mem_strb;

  // a poke entry writes memory instead of issuing a request
  string tname [MAX_ENTRIES];
  dcache_pkg::op_e t_op [MAX_ENTRIES];
  dcache_pkg::addr_t t_addr [MAX_ENTRIES];
  dcache_pkg::word_t t_wdata [MAX_ENTRIES];
  dcache_pkg::strobe_t t_strobe [MAX_ENTRIES];
  logic t_unc [MAX_ENTRIES];
  logic t_poke [MAX_ENTRIES];
  dcache_pkg::word_t t_exp [MAX_ENTRIES];
  int n_entries = 0;

  // expected read words in request order
  dcache_pkg::word_t exp_q [$];
  string name_q [$];
  int err_cnt = 0;
  int check_cnt = 0;
  int read_cnt = 0;
  int result_cnt = 0;
  logic timed_out = 1'b0;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  dcache_top dcache_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid_i   (ex_valid),
    .ex_op_i      (ex_op),
    .ex_addr_i    (ex_addr),
    .ex_wdata_i   (ex_wdata),
    .ex_strobe_i  (ex_strobe),
    .ex_uncached_i(ex_uncached),
    .busy_o       (busy),
    .rdata_o      (rdata),
    .rvalid_o     (rvalid),
    .mem_req_o    (mem_req),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_strb_o   (mem_strb),
    .mem_ack_i    (mem_ack),
    .mem_rdata_i  (mem_rdata)
  );

  dcache_mem_model mem_model_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .req_i  (mem_req),
    .we_i   (mem_we),
    .addr_i (mem_addr),
    .wdata_i(mem_wdata),
    .strb_i (mem_strb),
    .ack_o  (mem_ack),
    .rdata_o(mem_rdata)
  );

  // initial memory contents
  function automatic dcache_pkg::word_t rule_word(input dcache_pkg::addr_t addr);
    return addr ^ 32'hA5A5A5A5;
  endfunction

  function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_word,
                                                    input dcache_pkg::word_t new_word,
                                                    input dcache_pkg::strobe_t strb);
    dcache_pkg::word_t val;
    val = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        val[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return val;
  endfunction

  task automatic add_entry(input string name, input dcache_pkg::op_e op,
                           input dcache_pkg::addr_t addr, input dcache_pkg::word_t wdata,
                           input dcache_pkg::strobe_t strobe, input logic unc,
                           input logic poke, input dcache_pkg::word_t exp);
    tname[n_entries] = name;
    t_op[n_entries] = op;
    t_addr[n_entries] = addr;
    t_wdata[n_entries] = wdata;
    t_strobe[n_entries] = strobe;
    t_unc[n_entries] = unc;
    t_poke[n_entries] = poke;
    t_exp[n_entries] = exp;
    n_entries++;
  endtask

  task automatic build_table();
    dcache_pkg::word_t merged;
    // miss then hit
    add_entry("miss_read", dcache_pkg::OP_READ, 32'h100, 0, 0, 0, 0, rule_word(32'h100));
    add_entry("hit_read", dcache_pkg::OP_READ, 32'h100, 0, 0, 0, 0, rule_word(32'h100));
    // write hit forwarded into the next read and written through to memory
    merged = merge_bytes(rule_word(32'h200), 32'h11223344, 4'b0011);
    add_entry("fill_for_write", dcache_pkg::OP_READ, 32'h200, 0, 0, 0, 0, rule_word(32'h200));
    add_entry("hit_write", dcache_pkg::OP_WRITE, 32'h200, 32'h11223344, 4'b0011, 0, 0, 0);
    add_entry("read_after_write", dcache_pkg::OP_READ, 32'h200, 0, 0, 0, 0, merged);
    add_entry("hit_write_through", dcache_pkg::OP_READ, 32'h200, 0, 0, 1, 0, merged);
    add_entry("poke_written", dcache_pkg::OP_READ, 32'h200, 32'hDEADBEEF, 0, 0, 1, 0);
    add_entry("cached_after_poke", dcache_pkg::OP_READ, 32'h200, 0, 0, 0, 0, merged);
    // write miss goes to memory and leaves the set empty
    merged = merge_bytes(rule_word(32'h300), 32'hAABBCCDD, 4'b1100);
    add_entry("miss_write", dcache_pkg::OP_WRITE, 32'h300, 32'hAABBCCDD, 4'b1100, 0, 0, 0);
    add_entry("miss_write_through", dcache_pkg::OP_READ, 32'h300, 0, 0, 1, 0, merged);
    merged = merge_bytes(32'h12345678, 32'hAABBCCDD, 4'b1100);
    add_entry("poke_missed", dcache_pkg::OP_READ, 32'h300, merged, 0, 0, 1, 0);
    add_entry("read_no_alloc", dcache_pkg::OP_READ, 32'h300, 0, 0, 0, 0, merged);
    // uncached read bypasses a cached line
    add_entry("fill_for_unc", dcache_pkg::OP_READ, 32'h400, 0, 0, 0, 0, rule_word(32'h400));
    add_entry("poke_unc", dcache_pkg::OP_READ, 32'h400, 32'h0BADF00D, 0, 0, 1, 0);
    add_entry("uncached_read", dcache_pkg::OP_READ, 32'h400, 0, 0, 1, 0, 32'h0BADF00D);
    add_entry("stale_cached", dcache_pkg::OP_READ, 32'h400, 0, 0, 0, 0, rule_word(32'h400));
    // invalidate drops the stale line
    add_entry("fill_for_inv", dcache_pkg::OP_READ, 32'h514, 0, 0, 0, 0, rule_word(32'h514));
    add_entry("poke_inv", dcache_pkg::OP_READ, 32'h514, 32'h5555AAAA, 0, 0, 1, 0);
    add_entry("invalidate", dcache_pkg::OP_INV, 32'h514, 0, 0, 0, 0, 0);
    add_entry("read_after_inv", dcache_pkg::OP_READ, 32'h514, 0, 0, 0, 0, 32'h5555AAAA);
    // back to back reads where 0x10 and 0x410 share set 4
    add_entry("b2b_0", dcache_pkg::OP_READ, 32'h010, 0, 0, 0, 0, rule_word(32'h010));
    add_entry("b2b_1", dcache_pkg::OP_READ, 32'h020, 0, 0, 0, 0, rule_word(32'h020));
    add_entry("b2b_2", dcache_pkg::OP_READ, 32'h410, 0, 0, 0, 0, rule_word(32'h410));
    add_entry("b2b_3", dcache_pkg::OP_READ, 32'h030, 0, 0, 0, 0, rule_word(32'h030));
    // pokes show that both ways still hold their lines
    add_entry("poke_way0", dcache_pkg::OP_READ, 32'h010, 32'hC0FFEE00, 0, 0, 1, 0);
    add_entry("poke_way1", dcache_pkg::OP_READ, 32'h410, 32'h0F0F0F0F, 0, 0, 1, 0);
    add_entry("b2b_way0", dcache_pkg::OP_READ, 32'h010, 0, 0, 0, 0, rule_word(32'h010));
    add_entry("b2b_way1", dcache_pkg::OP_READ, 32'h410, 0, 0, 0, 0, rule_word(32'h410));
  endtask

  task automatic check_word(input string name, input dcache_pkg::word_t exp,
                            input dcache_pkg::word_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    check_cnt++;
    if (act != exp) begin
      err_cnt++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    $display("ERROR: timed out waiting for %s", what);
  endtask

  // busy_o comes from registers only, so it is stable at the falling edge
  task automatic wait_idle(input string what);
    int cnt;
    cnt = 0;
    while (busy && !timed_out) begin
      @(negedge clk);
      cnt++;
      if (cnt >= WAIT_LIMIT) begin
        report_timeout(what);
      end
    end
  endtask

  // idle for longer than the pipeline depth means nothing is left in flight
  task automatic drain_pipeline();
    int idle_run;
    int cnt;
    idle_run = 0;
    cnt = 0;
    while (idle_run < 3 && !timed_out) begin
      @(negedge clk);
      cnt++;
      idle_run = busy ? 0 : idle_run + 1;
      if (cnt >= WAIT_LIMIT) begin
        report_timeout("pipeline to drain");
      end
    end
  endtask

  task automatic wait_results();
    int cnt;
    cnt = 0;
    while (exp_q.size() > 0 && !timed_out) begin
      @(negedge clk);
      cnt++;
      if (cnt >= WAIT_LIMIT) begin
        report_timeout("outstanding read results");
      end
    end
  endtask

  task automatic apply_entry(input int i);
    @(negedge clk);
    if (t_poke[i]) begin
      ex_valid = 1'b0;
      drain_pipeline();
      mem_model_inst.poke(t_addr[i], t_wdata[i]);
    end else begin
      ex_valid = 1'b1;
      ex_op = t_op[i];
      ex_addr = t_addr[i];
      ex_wdata = t_wdata[i];
      ex_strobe = t_strobe[i];
      ex_uncached = t_unc[i];
      if (t_op[i] == dcache_pkg::OP_READ) begin
        exp_q.push_back(t_exp[i]);
        name_q.push_back(tname[i]);
        read_cnt++;
      end
      // held until the cycle in which it is taken
      wait_idle(tname[i]);
    end
  endtask

  // registered results are compared away from the rising edge
  always @(negedge clk) begin
    if (rst_n && rvalid) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("ERROR: read result %h arrived with no read outstanding", rdata);
      end else begin
        check_word(name_q.pop_front(), exp_q.pop_front(), rdata);
        result_cnt++;
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    ex_valid = 1'b0;
    ex_op = dcache_pkg::OP_READ;
    ex_addr = '0;
    ex_wdata = '0;
    ex_strobe = '0;
    ex_uncached = 1'b0;
    build_table();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    wait_idle("reset tag sweep");
    for (int i = 0; i < n_entries; i++) begin
      if (!timed_out) begin
        apply_entry(i);
      end
    end
    @(negedge clk);
    ex_valid = 1'b0;
    drain_pipeline();
    wait_results();
    if (exp_q.size() > 0) begin
      err_cnt++;
      $display("ERROR: %0d read results never arrived", exp_q.size());
    end
    check_count("read result count", read_cnt, result_cnt);
    err_cnt += mem_model_inst.overflow_cnt;
    $display("checks: %0d, errors: %0d, timeouts: %0d", check_cnt, err_cnt, timed_out);
    if (err_cnt == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
hw/dcache_pkg.sv
hw/dcache_ram.sv
hw/dcache_rport.sv
hw/dcache_wport.sv
hw/dcache_top.sv
verif/dcache_mem_model.sv
verif/dcache_tb.sv
